// File: common/cp0Pkg.sv
// Shared CP0 types and field positions; exception type encodings above excRefetch are unused
package cp0Pkg;

    parameter int wordWidth  = 32;
    parameter int hwIntCount = 6;

    // Status and Cause field positions
    parameter int statusBevBit = 22;
    parameter int statusImLow  = 8;
    parameter int statusExlBit = 1;
    parameter int statusIeBit  = 0;
    parameter int causeIpLow   = 8;
    parameter int causeExcLow  = 2;

    // Exception class presented by the memory stage each cycle
    typedef enum logic [3:0] {
        excNone,
        excInterrupt,
        excAddrFetch,   // Address error on fetch
        excAddrLoad,
        excAddrStore,
        excReserved,
        excSyscall,
        excBreak,
        excTrap,
        excOverflow,
        excCpU,
        excEret,
        excRefetch
    } excType_e;

    typedef enum logic [4:0] {
        codeInt  = 5'd0,
        codeAdEL = 5'd4,
        codeAdES = 5'd5,
        codeSys  = 5'd8,
        codeBp   = 5'd9,
        codeRI   = 5'd10,
        codeCpU  = 5'd11,
        codeOv   = 5'd12,
        codeTr   = 5'd13
    } excCode_e;

    typedef enum logic [4:0] {
        regBadVAddr = 5'd8,
        regCount    = 5'd9,
        regCompare  = 5'd11,
        regStatus   = 5'd12,
        regCause    = 5'd13,
        regEpc      = 5'd14
    } cp0Addr_e;

endpackage

// File: timer/countTimer.sv
// Count/Compare timer; Count ticks every countDivide cycles, Compare resets to all ones
`timescale 1ns/1ns

module countTimer #(
    parameter int countDivide = 2
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              writeEnable,
    input  cp0Pkg::cp0Addr_e                  writeAddr,
    input  logic [cp0Pkg::wordWidth-1:0]      writeData,
    output logic [cp0Pkg::wordWidth-1:0]      count,
    output logic [cp0Pkg::wordWidth-1:0]      compare,
    output logic                              timerInterrupt,
    output logic                              causeTi
);
    import cp0Pkg::*;

    localparam int prescWidth = (countDivide > 1) ? $clog2(countDivide) : 1;
    localparam logic [prescWidth-1:0] prescLast = prescWidth'(countDivide - 1);

    logic [prescWidth-1:0] prescaler;
    logic countWrite;
    logic compareWrite;

    assign countWrite   = writeEnable && (writeAddr == regCount);
    assign compareWrite = writeEnable && (writeAddr == regCompare);

    always_ff @(posedge clk) begin
        if (reset) begin
            prescaler <= '0;
            count     <= '0;
        end else if (countWrite) begin
            prescaler <= '0;   // Full period before the first tick
            count     <= writeData;
        end else if (prescaler == prescLast) begin
            prescaler <= '0;
            count     <= count + 1'b1;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '1;
        end else if (compareWrite) begin
            compare <= writeData;
        end
    end

    assign timerInterrupt = (count == compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            causeTi <= 1'b0;
        end else if (compareWrite) begin
            causeTi <= 1'b0;   // Acknowledge wins over a fresh match
        end else if (timerInterrupt) begin
            causeTi <= 1'b1;
        end
    end

    dividerValid: assert property (@(posedge clk) countDivide >= 1);
    tiClearedByCompare: assert property (@(posedge clk) disable iff (reset)
        compareWrite |=> !causeTi);

endmodule

// File: exception/exceptionLevelFsm.sv
// EXL state machine; exceptions outrank a Status write, recordEnable is combinational
`timescale 1ns/1ns

module exceptionLevelFsm (
    input  logic                              clk,
    input  logic                              reset,
    input  cp0Pkg::excType_e                  excType,
    input  logic                              writeEnable,
    input  cp0Pkg::cp0Addr_e                  writeAddr,
    input  logic [cp0Pkg::wordWidth-1:0]      writeData,
    output logic                              exl,
    output logic                              recordEnable
);
    import cp0Pkg::*;

    typedef enum logic {levelNormal, levelException} level_e;

    level_e state;
    level_e nextState;
    logic   excAccepted;
    logic   statusWrite;

    assign excAccepted = (excType != excNone) && (excType != excRefetch)
                      && (excType != excEret);
    assign statusWrite = writeEnable && (writeAddr == regStatus);

    always_comb begin
        nextState = state;
        if (excAccepted) begin
            nextState = levelException;
        end else if (excType == excEret) begin
            nextState = levelNormal;
        end else if (statusWrite) begin
            nextState = writeData[statusExlBit] ? levelException : levelNormal;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= levelNormal;
        end else begin
            state <= nextState;
        end
    end

    assign exl          = (state == levelException);
    assign recordEnable = excAccepted && (state == levelNormal);   // Nested ones keep EPC

    recordOnlyFromNormal: assert property (@(posedge clk) disable iff (reset)
        recordEnable |-> (state == levelNormal) ##1 (state == levelException));

endmodule

// File: exception/exceptionRecord.sv
// EPC, BadVAddr, ExcCode, BD and CE capture; EPC and BD only update on recordEnable or EPC write
`timescale 1ns/1ns

module exceptionRecord (
    input  logic                              clk,
    input  logic                              reset,
    input  cp0Pkg::excType_e                  excType,
    input  logic [cp0Pkg::wordWidth-1:0]      excPc,
    input  logic                              excInDelaySlot,
    input  logic [cp0Pkg::wordWidth-1:0]      excBadAddr,
    input  logic                              recordEnable,
    input  logic                              writeEnable,
    input  cp0Pkg::cp0Addr_e                  writeAddr,
    input  logic [cp0Pkg::wordWidth-1:0]      writeData,
    output logic [cp0Pkg::wordWidth-1:0]      epc,
    output logic [cp0Pkg::wordWidth-1:0]      badVAddr,
    output cp0Pkg::excCode_e                  excCode,
    output logic                              causeBd,
    output logic [1:0]                        causeCe
);
    import cp0Pkg::*;

    logic epcWrite;

    assign epcWrite = writeEnable && (writeAddr == regEpc);

    always_ff @(posedge clk) begin
        if (reset) begin
            excCode <= codeInt;
        end else begin
            case (excType)
                excInterrupt: excCode <= codeInt;
                excAddrFetch: excCode <= codeAdEL;
                excAddrLoad:  excCode <= codeAdEL;
                excAddrStore: excCode <= codeAdES;
                excReserved:  excCode <= codeRI;
                excSyscall:   excCode <= codeSys;
                excBreak:     excCode <= codeBp;
                excTrap:      excCode <= codeTr;
                excOverflow:  excCode <= codeOv;
                excCpU:       excCode <= codeCpU;
                default:      excCode <= excCode;   // None, ERET, refetch
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badVAddr <= '0;
        end else if (excType == excAddrFetch) begin
            badVAddr <= excPc;
        end else if (excType == excAddrLoad || excType == excAddrStore) begin
            badVAddr <= excBadAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc     <= '0;
            causeBd <= 1'b0;
        end else if (recordEnable) begin
            // Restart at the branch when faulting in its delay slot
            epc     <= excInDelaySlot ? excPc - wordWidth'(4) : excPc;
            causeBd <= excInDelaySlot;
        end else if (epcWrite) begin
            epc     <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            causeCe <= 2'd0;
        end else if (excType == excCpU) begin
            causeCe <= 2'd1;   // Only CP1 can be unusable here
        end
    end

    excTypeLegal: assert property (@(posedge clk) disable iff (reset)
        excType <= excRefetch);

endmodule

// File: source/statusCauseRegs.sv
// Status BEV/IM/IE and Cause IP; hardware IP bits lag the interrupt lines by one cycle
`timescale 1ns/1ns

module statusCauseRegs (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              writeEnable,
    input  cp0Pkg::cp0Addr_e                  writeAddr,
    input  logic [cp0Pkg::wordWidth-1:0]      writeData,
    input  logic [cp0Pkg::hwIntCount-1:0]     interrupt,
    input  logic                              timerInterrupt,
    output logic                              statusBev,
    output logic [cp0Pkg::hwIntCount+1:0]     statusIm,
    output logic                              statusIe,
    output logic [cp0Pkg::hwIntCount+1:0]     causeIp
);
    import cp0Pkg::*;

    logic statusWrite;
    logic causeWrite;
    logic [hwIntCount-1:0] hwLines;

    assign statusWrite = writeEnable && (writeAddr == regStatus);
    assign causeWrite  = writeEnable && (writeAddr == regCause);

    // Timer shares the top hardware line (IP7)
    assign hwLines = interrupt | {timerInterrupt, {(hwIntCount-1){1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            statusBev <= 1'b1;   // Boot vectors after reset
            statusIm  <= '0;
            statusIe  <= 1'b0;
        end else if (statusWrite) begin
            statusBev <= writeData[statusBevBit];
            statusIm  <= writeData[statusImLow +: hwIntCount+2];
            statusIe  <= writeData[statusIeBit];
        end
    end

    // Hardware pending bits, sampled every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            causeIp[hwIntCount+1:2] <= '0;
        end else begin
            causeIp[hwIntCount+1:2] <= hwLines;
        end
    end

    // Software interrupt requests
    always_ff @(posedge clk) begin
        if (reset) begin
            causeIp[1:0] <= 2'b00;
        end else if (causeWrite) begin
            causeIp[1:0] <= writeData[causeIpLow +: 2];
        end
    end

endmodule

// File: source/cp0ReadPort.sv
// Combinational CP0 read mux; unimplemented addresses read as zero
`timescale 1ns/1ns

module cp0ReadPort (
    input  cp0Pkg::cp0Addr_e                  readAddr,
    input  logic [cp0Pkg::wordWidth-1:0]      count,
    input  logic [cp0Pkg::wordWidth-1:0]      compare,
    input  logic [cp0Pkg::wordWidth-1:0]      badVAddr,
    input  logic [cp0Pkg::wordWidth-1:0]      epc,
    input  logic                              statusBev,
    input  logic [cp0Pkg::hwIntCount+1:0]     statusIm,
    input  logic                              exl,
    input  logic                              statusIe,
    input  logic                              causeBd,
    input  logic                              causeTi,
    input  logic [1:0]                        causeCe,
    input  logic [cp0Pkg::hwIntCount+1:0]     causeIp,
    input  cp0Pkg::excCode_e                  excCode,
    output logic [cp0Pkg::wordWidth-1:0]      readData
);
    import cp0Pkg::*;

    always_comb begin
        readData = '0;
        case (readAddr)
            regBadVAddr: readData = badVAddr;
            regCount:    readData = count;
            regCompare:  readData = compare;
            regEpc:      readData = epc;
            regStatus: begin
                readData[statusBevBit]                 = statusBev;
                readData[statusImLow +: hwIntCount+2] = statusIm;
                readData[statusExlBit]                 = exl;
                readData[statusIeBit]                  = statusIe;
            end
            regCause: begin
                readData[31]                          = causeBd;
                readData[30]                          = causeTi;
                readData[29:28]                       = causeCe;
                readData[causeIpLow +: hwIntCount+2] = causeIp;
                readData[causeExcLow +: 5]            = excCode;
            end
            default: readData = '0;
        endcase
    end

endmodule

// File: source/cp0Top.sv
// CP0 without TLB or config registers; countDivide must be at least 1, no back-pressure
`timescale 1ns/1ns

module cp0Top #(
    parameter int countDivide = 2
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cp0Pkg::hwIntCount-1:0]     interrupt,
    input  logic                              writeEnable,
    input  cp0Pkg::cp0Addr_e                  writeAddr,
    input  logic [cp0Pkg::wordWidth-1:0]      writeData,
    input  cp0Pkg::cp0Addr_e                  readAddr,
    output logic [cp0Pkg::wordWidth-1:0]      readData,
    input  cp0Pkg::excType_e                  excType,
    input  logic [cp0Pkg::wordWidth-1:0]      excPc,
    input  logic                              excInDelaySlot,
    input  logic [cp0Pkg::wordWidth-1:0]      excBadAddr,
    output logic                              statusBev,
    output logic [cp0Pkg::hwIntCount+1:0]     statusIm,
    output logic                              statusExl,
    output logic                              statusIe,
    output logic [cp0Pkg::hwIntCount+1:0]     causeIp,
    output logic [cp0Pkg::wordWidth-1:0]      epc
);
    import cp0Pkg::*;

    logic [wordWidth-1:0] count;
    logic [wordWidth-1:0] compare;
    logic [wordWidth-1:0] badVAddr;
    logic                 timerInterrupt;
    logic                 causeTi;
    logic                 recordEnable;
    logic                 causeBd;
    logic [1:0]           causeCe;
    excCode_e             excCode;

    countTimer #(.countDivide(countDivide)) u_countTimer (
        .clk(clk), .reset(reset),
        .writeEnable(writeEnable), .writeAddr(writeAddr), .writeData(writeData),
        .count(count), .compare(compare),
        .timerInterrupt(timerInterrupt), .causeTi(causeTi)
    );

    exceptionLevelFsm u_exceptionLevelFsm (
        .clk(clk), .reset(reset), .excType(excType),
        .writeEnable(writeEnable), .writeAddr(writeAddr), .writeData(writeData),
        .exl(statusExl), .recordEnable(recordEnable)
    );

    statusCauseRegs u_statusCauseRegs (
        .clk(clk), .reset(reset),
        .writeEnable(writeEnable), .writeAddr(writeAddr), .writeData(writeData),
        .interrupt(interrupt), .timerInterrupt(timerInterrupt),
        .statusBev(statusBev), .statusIm(statusIm), .statusIe(statusIe), .causeIp(causeIp)
    );

    exceptionRecord u_exceptionRecord (
        .clk(clk), .reset(reset), .excType(excType), .excPc(excPc),
        .excInDelaySlot(excInDelaySlot), .excBadAddr(excBadAddr),
        .recordEnable(recordEnable),
        .writeEnable(writeEnable), .writeAddr(writeAddr), .writeData(writeData),
        .epc(epc), .badVAddr(badVAddr), .excCode(excCode),
        .causeBd(causeBd), .causeCe(causeCe)
    );

    cp0ReadPort u_cp0ReadPort (
        .readAddr(readAddr), .count(count), .compare(compare),
        .badVAddr(badVAddr), .epc(epc),
        .statusBev(statusBev), .statusIm(statusIm), .exl(statusExl), .statusIe(statusIe),
        .causeBd(causeBd), .causeTi(causeTi), .causeCe(causeCe), .causeIp(causeIp),
        .excCode(excCode), .readData(readData)
    );

endmodule

// File: testbench/cp0Tests.svh
// Directed CP0 tests run in order; each leaves EXL clear and the interrupt lines low

task automatic resetStateTest();
    logic [31:0] data;
    readReg(regStatus, data);
    checkEqual("status", 32'h0040_0000, data);
    readReg(regCause, data);
    checkEqual("cause", 32'h0, data);
    readReg(regEpc, data);
    checkEqual("epc", 32'h0, data);
    checkEqual("causeIp", 32'h0, causeIp);
    checkEqual("statusBev", 32'h1, statusBev);
    checkEqual("statusExl", 32'h0, statusExl);
    checkEqual("statusIe", 32'h0, statusIe);
    readReg(cp0Addr_e'(5'd3), data);   // No register here
    checkEqual("unimplemented read", 32'h0, data);
endtask

task automatic registerWriteTest();
    logic [31:0] value;
    logic [31:0] data;
    value = $urandom();
    writeReg(regStatus, value);
    readReg(regStatus, data);
    checkEqual("status", value & statusMask, data);
    checkEqual("statusBev", value[22], statusBev);
    checkEqual("statusIm", value[15:8], statusIm);
    checkEqual("statusExl", value[1], statusExl);
    checkEqual("statusIe", value[0], statusIe);
    value = $urandom();
    writeReg(regCause, value);
    readReg(regCause, data);
    checkEqual("cause", value & 32'h0000_0300, data);   // Only IP1..0
    value = $urandom();
    writeReg(regEpc, value);
    readReg(regEpc, data);
    checkEqual("epc read", value, data);
    checkEqual("epc", value, epc);
    value = $urandom();
    writeReg(regCompare, value);
    readReg(regCompare, data);
    checkEqual("compare", value, data);
    writeReg(regStatus, 32'h0040_0000);
endtask

task automatic countPacingTest();
    logic [31:0] start;
    logic [31:0] data;
    start = $urandom();
    writeReg(regCount, start);
    readReg(regCount, data);
    checkEqual("count", start, data);
    repeat (tickPeriod - 1) stepCycle();
    readReg(regCount, data);
    checkEqual("count before first tick", start, data);
    stepCycle();
    readReg(regCount, data);
    checkEqual("count after 1 tick", start + 32'd1, data);
    repeat (3 * tickPeriod) stepCycle();
    readReg(regCount, data);
    checkEqual("count after 4 ticks", start + 32'd4, data);
endtask

task automatic timerInterruptTest();
    logic [31:0] start;
    logic [31:0] data;
    logic [5:0]  lines;
    int          waited;
    start = $urandom() & 32'h0fff_ffff;
    writeReg(regCount, start);
    writeReg(regCompare, start + 32'd3);
    waited = 0;
    while (causeIp[7] !== 1'b1) begin
        if (waited == 40) begin
            failRun("timed out waiting for the timer interrupt in causeIp bit 7");
        end else begin
            stepCycle();
            waited++;
        end
    end
    readReg(regCause, data);
    checkEqual("cause TI", 32'h1, data[30]);
    checkEqual("cause IP7", 32'h1, data[15]);
    writeReg(regCompare, start + 32'h1000);   // Acknowledge
    readReg(regCause, data);
    checkEqual("cause TI after compare write", 32'h0, data[30]);
    lines = 6'($urandom()) | 6'b000001;
    interrupt = lines;
    stepCycle();
    checkEqual("causeIp hardware", lines, causeIp[7:2]);
    interrupt = '0;
    stepCycle();
    checkEqual("causeIp hardware cleared", 32'h0, causeIp[7:2]);
endtask

task automatic exceptionEntryTest();
    logic [31:0] pc;
    logic [31:0] data;
    pc = $urandom() & 32'hffff_fffc;
    raiseException(excSyscall, pc, 1'b1, 32'h0);
    checkEqual("epc", pc - 32'd4, epc);   // Branch address
    readReg(regCause, data);
    checkEqual("cause BD", 32'h1, data[31]);
    checkEqual("cause ExcCode", 32'd8, data[6:2]);
    checkEqual("statusExl", 32'h1, statusExl);
    raiseException(excOverflow, pc + 32'h40, 1'b0, 32'h0);
    readReg(regCause, data);
    checkEqual("cause ExcCode", 32'd12, data[6:2]);
    checkEqual("cause BD", 32'h1, data[31]);
    checkEqual("epc", pc - 32'd4, epc);
    raiseException(excEret, 32'h0, 1'b0, 32'h0);
    checkEqual("statusExl", 32'h0, statusExl);
    raiseException(excCpU, pc + 32'h80, 1'b0, 32'h0);
    readReg(regCause, data);
    checkEqual("cause CE", 32'h1, data[29:28]);
    checkEqual("cause ExcCode", 32'd11, data[6:2]);
    raiseException(excEret, 32'h0, 1'b0, 32'h0);
endtask

task automatic addressErrorTest();
    logic [31:0] pc;
    logic [31:0] badAddr;
    logic [31:0] data;
    pc = $urandom();
    raiseException(excAddrFetch, pc, 1'b0, 32'h0);
    readReg(regBadVAddr, data);
    checkEqual("badVAddr fetch", pc, data);
    readReg(regCause, data);
    checkEqual("cause ExcCode", 32'd4, data[6:2]);
    badAddr = $urandom();
    raiseException(excAddrStore, pc + 32'd4, 1'b0, badAddr);
    readReg(regBadVAddr, data);
    checkEqual("badVAddr store", badAddr, data);
    readReg(regCause, data);
    checkEqual("cause ExcCode", 32'd5, data[6:2]);
    raiseException(excEret, 32'h0, 1'b0, 32'h0);
    raiseException(excRefetch, ~pc, 1'b1, ~badAddr);   // Must be ignored
    readReg(regBadVAddr, data);
    checkEqual("badVAddr after refetch", badAddr, data);
    readReg(regCause, data);
    checkEqual("cause ExcCode after refetch", 32'd5, data[6:2]);
    checkEqual("cause BD after refetch", 32'h0, data[31]);
    checkEqual("epc after refetch", pc, epc);   // Still the fetch fault
    checkEqual("statusExl after refetch", 32'h0, statusExl);
endtask

// File: testbench/cp0Tb.sv
// CP0 testbench; expects countDivide 2, stops with $fatal at the first failing check
`timescale 1ns/1ns

module cp0Tb;
    import cp0Pkg::*;

    localparam int tickPeriod = 2;
    localparam logic [31:0] statusMask = 32'h0040_ff03;   // BEV, IM, EXL, IE

    logic        clk;
    logic        reset;
    logic [5:0]  interrupt;
    logic        writeEnable;
    cp0Addr_e    writeAddr;
    logic [31:0] writeData;
    cp0Addr_e    readAddr;
    logic [31:0] readData;
    excType_e    excType;
    logic [31:0] excPc;
    logic        excInDelaySlot;
    logic [31:0] excBadAddr;
    logic        statusBev;
    logic [7:0]  statusIm;
    logic        statusExl;
    logic        statusIe;
    logic [7:0]  causeIp;
    logic [31:0] epc;

    cp0Top #(.countDivide(tickPeriod)) u_dut (
        .clk(clk), .reset(reset), .interrupt(interrupt),
        .writeEnable(writeEnable), .writeAddr(writeAddr), .writeData(writeData),
        .readAddr(readAddr), .readData(readData),
        .excType(excType), .excPc(excPc), .excInDelaySlot(excInDelaySlot),
        .excBadAddr(excBadAddr),
        .statusBev(statusBev), .statusIm(statusIm), .statusExl(statusExl),
        .statusIe(statusIe), .causeIp(causeIp), .epc(epc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("mismatch at %0t ns: %s expected %h actual %h",
                              $time, name, expected, actual));
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic writeReg(input cp0Addr_e addr, input logic [31:0] data);
        writeEnable = 1'b1;
        writeAddr   = addr;
        writeData   = data;
        stepCycle();
        writeEnable = 1'b0;
    endtask

    task automatic readReg(input cp0Addr_e addr, output logic [31:0] data);
        readAddr = addr;
        #1;   // Let the read mux settle
        data = readData;
    endtask

    task automatic raiseException(input excType_e kind, input logic [31:0] pc,
                                  input logic inSlot, input logic [31:0] badAddr);
        excType        = kind;
        excPc          = pc;
        excInDelaySlot = inSlot;
        excBadAddr     = badAddr;
        stepCycle();
        excType        = excNone;
        excInDelaySlot = 1'b0;
    endtask

    `include "cp0Tests.svh"

    initial begin
        void'($urandom(32'hbbfda448));
        reset          = 1'b1;
        interrupt      = '0;
        writeEnable    = 1'b0;
        writeAddr      = regStatus;
        writeData      = '0;
        readAddr       = regStatus;
        excType        = excNone;
        excPc          = '0;
        excInDelaySlot = 1'b0;
        excBadAddr     = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        resetStateTest();
        registerWriteTest();
        countPacingTest();
        timerInterruptTest();
        exceptionEntryTest();
        addressErrorTest();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+testbench
common/cp0Pkg.sv
timer/countTimer.sv
exception/exceptionLevelFsm.sv
exception/exceptionRecord.sv
source/statusCauseRegs.sv
source/cp0ReadPort.sv
source/cp0Top.sv
testbench/cp0Tb.sv
